//--- build.f
+incdir+src
src/fetch_pkg.sv
src/fetch_branch_predecode.sv
src/fetch_pc_gen.sv
src/icache_store.sv
src/icache_refill_counter.sv
src/icache_refill_fsm.sv
src/fetch_top.sv
verif/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch stage testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fetch_tb -f build.f -o fetch_sim \
	|| { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/fetch_sim)
echo "$out"

echo "$out" | grep -q "^Testbench passed$" && exit 0 || exit 1

//--- verif/fetch_tb.sv
`include "fetch_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module fetch_tb
	import fetch_pkg::*;
;

	localparam pc_t RESET_PC    = `FETCH_RESET_PC;
	localparam int  IMAGE_WORDS = 64;

	logic       clk;
	logic       rst;
	logic       fetch_valid;
	logic       fetch_ready;
	pc_t        fetch_pc;
	inst_word_u fetch_inst;
	logic       redirect;
	pc_t        redirect_pc;
	logic       inval_en;
	pc_t        inval_addr;
	logic       mem_req;
	pc_t        mem_addr;
	logic       mem_ack;
	inst_word_u mem_rdata;

	// program image, 16 lines starting at the reset pc
	logic [31:0] mem_image [IMAGE_WORDS];
	logic [31:0] lcg_state = 32'd68577;

	int         errors      = 0;
	int         checks      = 0;
	int         accept_cnt  = 0;
	int         req_rises   = 0;
	int         taken_cnt   = 0;
	logic       timed_out   = 1'b0;
	logic       offer_valid = 1'b0;
	pc_t        offer_pc    = '0;
	inst_word_u offer_inst;
	pc_t        last_acc_pc = '0;
	pc_t        exp_pc;
	logic       prev_stall;
	logic       prev_req;
	logic       prev_ack;
	pc_t        prev_pc;
	inst_word_u prev_inst;

	fetch_top fetch_top_inst (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_ready (fetch_ready),
		.fetch_pc    (fetch_pc),
		.fetch_inst  (fetch_inst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inval_en    (inval_en),
		.inval_addr  (inval_addr),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ************************************************************
	// stimulus helpers
	// ************************************************************

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// addi-style word, immediate folded from every address bit
	function automatic logic [31:0] alu_word(input pc_t addr, input logic [31:0] rnd);
		logic [31:0] f;
		logic [11:0] imm;
		f   = addr[63:32] ^ addr[31:0];
		imm = f[31:20] ^ f[19:8] ^ {4'b0, f[7:0]};
		return {imm, rnd[4:0], 3'b000, rnd[9:5], 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_branch(input int off, input logic [31:0] rnd);
		logic [31:0] o;
		o = off;
		return {o[12], o[10:5], rnd[4:0], rnd[9:5], rnd[12:10], o[4:1], o[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input int off, input logic [31:0] rnd);
		logic [31:0] o;
		o = off;
		return {o[20], o[10:1], o[11], o[19:12], rnd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] mem_word(input pc_t addr);
		pc_t idx;
		idx = (addr - RESET_PC) >> 2;
		if (idx >= IMAGE_WORDS) begin
			return 32'h0;
		end
		return mem_image[idx[5:0]];
	endfunction

	// static rule: jal taken, conditional branch taken only backwards
	function automatic pc_t ref_next_pc(input pc_t pc, input logic [31:0] w);
		pc_t off_b;
		pc_t off_j;
		off_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		off_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		if (w[6:0] == 7'b1101111) begin
			return pc + off_j;
		end else if (w[6:0] == 7'b1100011 && w[31]) begin
			return pc + off_b;
		end
		return pc + 64'd4;
	endfunction

	// mixed image, every target stays inside it
	task automatic build_image();
		logic [31:0] r;
		int          t;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			r = lcg_next();
			t = int'(r[21:16]);
			if (i == IMAGE_WORDS - 1) begin
				// last word loops back to the start
				mem_image[i] = enc_jal(-i * 4, r);
			end else if (r[30:28] == 3'd4) begin
				if (t == i) begin
					t = i + 1;
				end
				mem_image[i] = enc_jal((t - i) * 4, r);
			end else if (r[30:28] == 3'd5) begin
				t = i + 1 + (t % (IMAGE_WORDS - 1 - i));
				mem_image[i] = enc_branch((t - i) * 4, r);
			end else if (r[30:28] == 3'd6 && i > 0) begin
				t = t % i;
				mem_image[i] = enc_branch((t - i) * 4, r);
			end else begin
				mem_image[i] = alu_word(RESET_PC + pc_t'(i * 4), r);
			end
		end
	endtask

	// ************************************************************
	// compare tasks
	// ************************************************************

	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_inst(input string name, input inst_word_u got, input inst_word_u exp);
		checks++;
		if (got.raw !== exp.raw) begin
			errors++;
			$display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got.raw, exp.raw);
		end
	endtask

	task automatic fail_plain(input string what);
		errors++;
		$display("At %0t: %s", $time, what);
	endtask

	// ************************************************************
	// memory model, four-phase with 0 to 3 cycles of latency
	// ************************************************************

	initial begin : mem_model
		logic [31:0] r;
		logic [31:0] w;
		pc_t         a;
		int          n;
		mem_ack       = 1'b0;
		mem_rdata.raw = '0;
		forever begin
			@(negedge clk);
			if (!rst && mem_req && !mem_ack) begin
				a = mem_addr;
				w = mem_word(a);
				if (a < RESET_PC || a >= RESET_PC + pc_t'(IMAGE_WORDS * 4)) begin
					fail_plain("memory read outside the program image");
				end
				r = lcg_next();
				repeat (int'(r[17:16])) @(posedge clk);
				@(posedge clk);
				#1;
				mem_ack       = 1'b1;
				mem_rdata.raw = w;
				n = 0;
				while (mem_req && n < 16) begin
					@(negedge clk);
					n++;
				end
				if (mem_req) begin
					fail_plain("mem_req stayed high 16 cycles after mem_ack");
				end
				@(posedge clk);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	// ************************************************************
	// compare process, samples at the falling edge
	// ************************************************************

	always @(negedge clk) begin : compare_proc
		logic [31:0] w;
		inst_word_u  exp_inst;
		if (rst) begin
			exp_pc     = RESET_PC;
			prev_stall = 1'b0;
			prev_req   = 1'b0;
			prev_ack   = 1'b0;
		end else begin
			// four-phase rules
			if (mem_req && !prev_req) begin
				req_rises++;
				if (mem_ack) begin
					fail_plain("mem_req rose while mem_ack was still high");
				end
			end
			if (!mem_req && prev_req && !prev_ack) begin
				fail_plain("mem_req dropped before mem_ack was seen");
			end
			// offer must hold under back-pressure
			if (prev_stall) begin
				if (!fetch_valid) begin
					fail_plain("offered instruction withdrawn while fetch_ready was low");
				end
				check_pc("fetch_pc", fetch_pc, prev_pc);
				check_inst("fetch_inst", fetch_inst, prev_inst);
			end
			if (redirect) begin
				exp_pc = redirect_pc;
			end else if (fetch_valid && fetch_ready) begin
				w            = mem_word(fetch_pc);
				exp_inst.raw = w;
				check_pc("fetch_pc", fetch_pc, exp_pc);
				check_inst("fetch_inst", fetch_inst, exp_inst);
				// follow the dut pc so one slip does not cascade
				exp_pc = ref_next_pc(fetch_pc, w);
				if (exp_pc != fetch_pc + 64'd4) begin
					taken_cnt++;
				end
				last_acc_pc = fetch_pc;
				accept_cnt++;
			end
			prev_stall = fetch_valid && !fetch_ready && !redirect && !inval_en;
			prev_pc    = fetch_pc;
			prev_inst  = fetch_inst;
			prev_req   = mem_req;
			prev_ack   = mem_ack;
		end
		offer_valid = fetch_valid;
		offer_pc    = fetch_pc;
		offer_inst  = fetch_inst;
	end

	// ************************************************************
	// sequencing
	// ************************************************************

	// drive point, 1 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic pulse_redirect(input pc_t target);
		redirect    = 1'b1;
		redirect_pc = target;
		tick();
		redirect = 1'b0;
	endtask

	task automatic wait_accepts(input int n, input int limit);
		int start;
		int cyc;
		start = accept_cnt;
		cyc   = 0;
		while (accept_cnt - start < n && cyc < limit) begin
			tick();
			cyc++;
		end
		if (accept_cnt - start < n) begin
			fail_plain($sformatf("timeout, %0d accepts not seen in %0d cycles", n, limit));
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_offer(input pc_t target, input int limit);
		int cyc;
		cyc = 0;
		while (!(offer_valid && offer_pc == target) && cyc < limit) begin
			tick();
			cyc++;
		end
		if (!(offer_valid && offer_pc == target)) begin
			fail_plain($sformatf("timeout, pc 0x%h never offered", target));
			timed_out = 1'b1;
		end
	endtask

	task automatic report(input int num, input string name, input int err_before);
		$display("test %0d %s: %0d errors", num, name, errors - err_before);
	endtask

	task automatic reset_and_first_fetch();
		int e;
		e = errors;
		checks++;
		if (fetch_valid || mem_req) begin
			fail_plain("fetch_valid or mem_req high during reset");
		end
		check_pc("fetch_pc", fetch_pc, RESET_PC);
		rst         = 1'b0;
		fetch_ready = 1'b1;
		wait_accepts(1, 300);
		check_pc("first accepted fetch_pc", last_acc_pc, RESET_PC);
		report(1, "reset and first fetch", e);
	endtask

	task automatic follow_predicted_flow();
		int e;
		e = errors;
		wait_accepts(150, 6000);
		checks++;
		if (taken_cnt == 0) begin
			fail_plain("no taken prediction was exercised");
		end
		report(2, "predicted flow", e);
	endtask

	task automatic redirect_bursts();
		int          e;
		logic [31:0] r;
		pc_t         target;
		e = errors;
		for (int k = 0; k < 12 && !timed_out; k++) begin
			r = lcg_next();
			repeat (int'(r[26:24])) tick();
			target = RESET_PC + pc_t'(r[21:16]) * 4;
			pulse_redirect(target);
			wait_accepts(1, 300);
			check_pc("fetch_pc after redirect", last_acc_pc, target);
		end
		report(3, "redirect", e);
	endtask

	task automatic ready_stretches();
		int          e;
		int          start;
		int          cyc;
		int          stretch;
		logic [31:0] r;
		e       = errors;
		start   = accept_cnt;
		cyc     = 0;
		stretch = 0;
		while (accept_cnt - start < 100 && cyc < 8000) begin
			if (stretch == 0) begin
				r           = lcg_next();
				fetch_ready = r[29];
				stretch     = 1 + int'(r[18:16]);
			end
			stretch--;
			tick();
			cyc++;
		end
		fetch_ready = 1'b1;
		if (accept_cnt - start < 100) begin
			fail_plain("timeout, back-pressure test stalled");
			timed_out = 1'b1;
		end
		report(4, "back-pressure", e);
	endtask

	task automatic snoop_rewrite();
		int         e;
		pc_t        a;
		pc_t        b;
		inst_word_u new_word;
		e = errors;
		// a and b sit in different cache lines
		a = RESET_PC + 64'd36;
		b = RESET_PC + 64'd80;
		fetch_ready = 1'b0;
		pulse_redirect(a);
		wait_offer(a, 400);
		pulse_redirect(b);
		wait_offer(b, 400);
		// code rewritten at a, then the store snoop
		new_word.raw = alu_word(a, 32'h0000_0321) ^ 32'hfff0_0000;
		mem_image[9] = new_word.raw;
		inval_en     = 1'b1;
		inval_addr   = a;
		tick();
		inval_en = 1'b0;
		tick();
		checks++;
		if (!(offer_valid && offer_pc == b)) begin
			fail_plain("snoop of another line dropped the offered instruction");
		end
		pulse_redirect(a);
		tick();
		checks++;
		if (offer_valid) begin
			fail_plain("invalidated line still hit after the snoop");
		end
		wait_offer(a, 400);
		check_inst("fetch_inst after snoop", offer_inst, new_word);
		pulse_redirect(b);
		tick();
		checks++;
		if (!(offer_valid && offer_pc == b)) begin
			fail_plain("untouched line missed after the snoop");
		end
		fetch_ready = 1'b1;
		wait_accepts(4, 400);
		report(5, "snoop invalidation", e);
	endtask

	task automatic handshake_summary();
		int e;
		e = errors;
		checks++;
		if (req_rises == 0) begin
			fail_plain("no memory handshake was observed");
		end
		$display("memory handshakes seen: %0d", req_rises);
		report(6, "memory handshake", e);
	endtask

	initial begin : main_seq
		rst         = 1'b1;
		fetch_ready = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		inval_en    = 1'b0;
		inval_addr  = '0;
		build_image();
		repeat (5) tick();
		reset_and_first_fetch();
		if (!timed_out) begin
			follow_predicted_flow();
		end
		if (!timed_out) begin
			redirect_bursts();
		end
		if (!timed_out) begin
			ready_stretches();
		end
		if (!timed_out) begin
			snoop_rewrite();
		end
		handshake_summary();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`include "fetch_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module fetch_top
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	output logic       fetch_valid,
	input  logic       fetch_ready,
	output pc_t        fetch_pc,
	output inst_word_u fetch_inst,
	input  logic       redirect,
	input  pc_t        redirect_pc,
	input  logic       inval_en,
	input  pc_t        inval_addr,
	output logic       mem_req,
	output pc_t        mem_addr,
	input  logic       mem_ack,
	input  inst_word_u mem_rdata
);

	pc_t                      pc;
	pc_t                      pred_target;
	pc_t                      fill_base;
	inst_word_u               hit_word;
	inst_word_u               word_data;
	logic                     pred_taken;
	logic                     hit;
	logic                     busy;
	logic                     miss;
	logic                     accept;
	logic                     word_we;
	logic                     line_done;
	logic                     cnt_clear;
	logic                     cnt_step;
	logic                     last_word;
	logic [`ICACHE_OFS_W-1:0] ofs;

	// ************************************************************
	// handshake glue
	// ************************************************************

	// nothing offered while a refill runs
	assign fetch_valid = hit && !busy;
	assign fetch_pc    = pc;
	assign fetch_inst  = hit_word;

	// a redirect cycle flushes the offered instruction
	assign accept = fetch_valid && fetch_ready && !redirect;
	assign miss   = !hit && !busy;

	fetch_branch_predecode predecode_inst (
		.inst        (hit_word),
		.pc          (pc),
		.pred_taken  (pred_taken),
		.pred_target (pred_target)
	);

	fetch_pc_gen pc_gen_inst (
		.clk         (clk),
		.rst         (rst),
		.accept      (accept),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pred_taken  (pred_taken),
		.pred_target (pred_target),
		.pc          (pc)
	);

	icache_store store_inst (
		.clk        (clk),
		.rst        (rst),
		.lookup_pc  (pc),
		.hit        (hit),
		.hit_word   (hit_word),
		.fill_base  (fill_base),
		.fill_ofs   (ofs),
		.word_we    (word_we),
		.word_data  (word_data),
		.line_done  (line_done),
		.inval_en   (inval_en),
		.inval_addr (inval_addr)
	);

	icache_refill_fsm refill_fsm_inst (
		.clk       (clk),
		.rst       (rst),
		.miss      (miss),
		.miss_pc   (pc),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.fill_base (fill_base),
		.word_we   (word_we),
		.word_data (word_data),
		.line_done (line_done),
		.busy      (busy),
		.cnt_clear (cnt_clear),
		.cnt_step  (cnt_step),
		.ofs       (ofs),
		.last_word (last_word)
	);

	icache_refill_counter refill_counter_inst (
		.clk       (clk),
		.rst       (rst),
		.clear     (cnt_clear),
		.step      (cnt_step),
		.ofs       (ofs),
		.last_word (last_word)
	);

endmodule

`default_nettype wire

//--- src/icache_refill_fsm.sv
`include "fetch_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module icache_refill_fsm
	import fetch_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     miss,
	input  pc_t                      miss_pc,
	output logic                     mem_req,
	output pc_t                      mem_addr,
	input  logic                     mem_ack,
	input  inst_word_u               mem_rdata,
	output pc_t                      fill_base,
	output logic                     word_we,
	output inst_word_u               word_data,
	output logic                     line_done,
	output logic                     busy,
	output logic                     cnt_clear,
	output logic                     cnt_step,
	input  logic [`ICACHE_OFS_W-1:0] ofs,
	input  logic                     last_word
);

	localparam int LINE_LSB = `ICACHE_OFS_W + 2;

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_ack_low,
		st_done
	} state_e;

	state_e state_q;
	pc_t    base_q;
	logic   last_q;
	logic   start;

	// ************************************************************
	// state machine
	// ************************************************************

	assign start = (state_q == st_idle) && miss;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
			last_q  <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (miss) begin
						state_q <= st_req;
					end
				end
				st_req: begin
					// word captured this edge, remember if it closes the line
					if (mem_ack) begin
						state_q <= st_ack_low;
						last_q  <= last_word;
					end
				end
				st_ack_low: begin
					// four-phase, wait out the ack before the next req
					if (!mem_ack) begin
						state_q <= last_q ? st_done : st_req;
					end
				end
				st_done: begin
					state_q <= st_idle;
				end
				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// line base, low bits cleared
	always_ff @(posedge clk) begin
		if (start) begin
			base_q <= {miss_pc[`FETCH_PC_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
		end
	end

	// ************************************************************
	// outputs
	// ************************************************************

	assign busy      = (state_q != st_idle);
	assign mem_req   = (state_q == st_req);
	assign mem_addr  = {base_q[`FETCH_PC_W-1:LINE_LSB], ofs, 2'b00};
	assign fill_base = base_q;

	// capture on the ack, req drops the cycle after
	assign word_we   = mem_req && mem_ack;
	assign word_data = mem_rdata;
	assign cnt_clear = start;
	assign cnt_step  = word_we;
	assign line_done = (state_q == st_done);

	// handshake rules against the memory side
	assert property (@(posedge clk) disable iff (rst)
		(mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr)))
		else $error("mem_req or mem_addr changed before mem_ack");

	assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem_req rose while mem_ack still high");

endmodule

`default_nettype wire

//--- src/icache_refill_counter.sv
`include "fetch_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module icache_refill_counter (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clear,
	input  logic                     step,
	output logic [`ICACHE_OFS_W-1:0] ofs,
	output logic                     last_word
);

	localparam int unsigned LAST = `ICACHE_WORDS - 1;

	logic [`ICACHE_OFS_W-1:0] ofs_q;

	// word offset within the line being refilled
	always_ff @(posedge clk) begin
		if (rst) begin
			ofs_q <= '0;
		end else if (clear) begin
			ofs_q <= '0;
		end else if (step) begin
			// wraps to zero after the last word
			ofs_q <= ofs_q + 1'b1;
		end
	end

	assign ofs       = ofs_q;
	assign last_word = (ofs_q == LAST[`ICACHE_OFS_W-1:0]);

endmodule

`default_nettype wire

//--- src/icache_store.sv
`include "fetch_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module icache_store
	import fetch_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  pc_t                      lookup_pc,
	output logic                     hit,
	output inst_word_u               hit_word,
	input  pc_t                      fill_base,
	input  logic [`ICACHE_OFS_W-1:0] fill_ofs,
	input  logic                     word_we,
	input  inst_word_u               word_data,
	input  logic                     line_done,
	input  logic                     inval_en,
	input  pc_t                      inval_addr
);

	localparam int LINES   = 1 << `ICACHE_IDX_W;
	localparam int IDX_LSB = `ICACHE_OFS_W + 2;
	localparam int TAG_LSB = `ICACHE_IDX_W + IDX_LSB;

	// ************************************************************
	// arrays
	// ************************************************************

	logic [LINES-1:0] valid_q;
	tag_t             tag_q [LINES];
	inst_word_u       data_q [LINES][`ICACHE_WORDS];

	logic [`ICACHE_IDX_W-1:0] look_idx;
	logic [`ICACHE_IDX_W-1:0] fill_idx;
	logic [`ICACHE_IDX_W-1:0] inval_idx;
	logic [`ICACHE_OFS_W-1:0] look_ofs;
	tag_t                     look_tag;
	tag_t                     fill_tag;
	tag_t                     inval_tag;
	logic                     fill_start;
	logic                     inval_hit;
	logic                     inval_fill;
	logic                     fill_stale_q;

	// address split
	assign look_idx  = lookup_pc[IDX_LSB +: `ICACHE_IDX_W];
	assign look_ofs  = lookup_pc[2 +: `ICACHE_OFS_W];
	assign look_tag  = lookup_pc[`FETCH_PC_W-1:TAG_LSB];
	assign fill_idx  = fill_base[IDX_LSB +: `ICACHE_IDX_W];
	assign fill_tag  = fill_base[`FETCH_PC_W-1:TAG_LSB];
	assign inval_idx = inval_addr[IDX_LSB +: `ICACHE_IDX_W];
	assign inval_tag = inval_addr[`FETCH_PC_W-1:TAG_LSB];

	// combinational lookup
	assign hit      = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
	assign hit_word = data_q[look_idx][look_ofs];

	// first refill word opens the line
	assign fill_start = word_we && (fill_ofs == '0);

	// snoop against a resident line, and against the line being filled
	assign inval_hit  = inval_en && valid_q[inval_idx] && (tag_q[inval_idx] == inval_tag);
	assign inval_fill = inval_en && (inval_idx == fill_idx) && (inval_tag == fill_tag);

	// ************************************************************
	// valid bits
	// ************************************************************

	// store into a line mid-refill, so drop it at the end
	always_ff @(posedge clk) begin
		if (rst) begin
			fill_stale_q <= 1'b0;
		end else if (fill_start) begin
			fill_stale_q <= inval_fill;
		end else if (inval_fill) begin
			fill_stale_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			if (fill_start) begin
				valid_q[fill_idx] <= 1'b0;
			end
			if (line_done && !fill_stale_q && !inval_fill) begin
				valid_q[fill_idx] <= 1'b1;
			end
			// snoop last, it wins
			if (inval_hit) begin
				valid_q[inval_idx] <= 1'b0;
			end
		end
	end

	// tag on first word, data per word
	always_ff @(posedge clk) begin
		if (fill_start) begin
			tag_q[fill_idx] <= fill_tag;
		end
		if (word_we) begin
			data_q[fill_idx][fill_ofs] <= word_data;
		end
	end

	// refill fsm never writes a word in its done cycle
	assert property (@(posedge clk) disable iff (rst) !(word_we && line_done))
		else $error("word write and line done in the same cycle");

endmodule

`default_nettype wire

//--- src/fetch_pc_gen.sv
`include "fetch_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen
	import fetch_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic accept,
	input  logic redirect,
	input  pc_t  redirect_pc,
	input  logic pred_taken,
	input  pc_t  pred_target,
	output pc_t  pc
);

	// ************************************************************
	// next pc select
	// ************************************************************

	pc_t  pc_q;
	pc_t  pc_next;
	pc_t  pc_seq;
	logic pc_en;

	// sequential fetch, no compressed instructions
	assign pc_seq = pc_q + `FETCH_PC_W'(4);

	always_comb begin
		pc_next = pc_q;
		pc_en   = 1'b0;
		if (redirect) begin
			// execute overrides everything, even back-pressure
			pc_next = redirect_pc;
			pc_en   = 1'b1;
		end else if (accept && pred_taken) begin
			pc_next = pred_target;
			pc_en   = 1'b1;
		end else if (accept) begin
			pc_next = pc_seq;
			pc_en   = 1'b1;
		end
		// otherwise hold, decode not ready or cache missing
	end

	// ************************************************************
	// pc register
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= `FETCH_RESET_PC;
		end else if (pc_en) begin
			pc_q <= pc_next;
		end
	end

	assign pc = pc_q;

endmodule

`default_nettype wire

//--- src/fetch_branch_predecode.sv
`include "fetch_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module fetch_branch_predecode
	import fetch_pkg::*;
(
	input  inst_word_u inst,
	input  pc_t        pc,
	output logic       pred_taken,
	output pc_t        pred_target
);

	// ************************************************************
	// immediates
	// ************************************************************

	pc_t  imm_b;
	pc_t  imm_j;
	logic is_jal;
	logic is_branch;

	// b-type, sign from bit 31, lsb always zero
	assign imm_b = {{(`FETCH_PC_W-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
		inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};

	// j-type, 21-bit signed offset
	assign imm_j = {{(`FETCH_PC_W-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
		inst.j.imm_11, inst.j.imm_10_1, 1'b0};

	// ************************************************************
	// static prediction
	// ************************************************************

	always_comb begin
		is_jal    = 1'b0;
		is_branch = 1'b0;
		case (inst.b.opcode)
			op_jal:    is_jal    = 1'b1;
			op_branch: is_branch = 1'b1;
			default:   ;
		endcase
	end

	// jal always, branch only when the offset points backwards
	assign pred_taken = is_jal | (is_branch & inst.b.imm_12);

	always_comb begin
		if (is_jal) begin
			pred_target = pc + imm_j;
		end else begin
			pred_target = pc + imm_b;
		end
	end

	// pc from pc_gen is word aligned, so any taken target must land on a halfword
	always_comb begin
		assert #0 (!pred_taken || !pred_target[0])
			else $error("predicted target 0x%h not halfword aligned", pred_target);
	end

endmodule

`default_nettype wire

//--- src/fetch_pkg.sv
`include "fetch_macros.svh"

`default_nettype none

package fetch_pkg;

	// tag sits above index, word offset and byte-in-word bits
	localparam int TAG_W = `FETCH_PC_W - `ICACHE_IDX_W - `ICACHE_OFS_W - 2;

	typedef logic [`FETCH_PC_W-1:0] pc_t;
	typedef logic [TAG_W-1:0] tag_t;

	// only the two control-flow opcodes matter to fetch
	typedef enum logic [6:0] {
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	// conditional branch layout
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} inst_b_t;

	// jal layout
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} inst_j_t;

	// one fetched word, seen raw or through either immediate layout
	typedef union packed {
		logic [31:0] raw;
		inst_b_t     b;
		inst_j_t     j;
	} inst_word_u;

endpackage

`default_nettype wire

//--- src/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

`default_nettype none

// ************************************************************
// fetch stage constants
// ************************************************************

// program counter and byte address width
`define FETCH_PC_W 64

// first pc after reset, start of dram
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// icache geometry, 8 lines of 4 words
`define ICACHE_IDX_W 3
`define ICACHE_OFS_W 2
`define ICACHE_WORDS 4

`default_nettype wire

`endif
